//--- common/io_pkg.sv
package io_pkg;

	// bus widths
	localparam int PORT_W = 16;
	localparam int DATA_W = 16;

	// port map
	localparam logic [PORT_W-1:0] PORT_LPT        = 16'h0378; // parallel sample latch
	localparam logic [PORT_W-1:0] PORT_DSP_STATUS = 16'h022a;
	localparam logic [PORT_W-1:0] PORT_DSP_CMD    = 16'h022c;
	localparam logic [PORT_W-1:0] PORT_DSP_FF     = 16'h022e; // always reads ffh
	localparam logic [PORT_W-1:0] PORT_SD         = 16'h03da; // bit-banged sd card

	// dsp command bytes
	localparam logic [7:0] DSP_CMD_DIRECT = 8'h10; // next byte is a sample
	localparam logic [7:0] DSP_CMD_ID     = 8'he1; // status reads 01h

	// audio path
	localparam int SAMPLE_W   = 16;
	localparam int ACC_W      = 32;
	localparam int LEAK_SHIFT = 7;
	localparam int STEP_BIT   = 25;

endpackage

//--- design/io_decode.sv
`timescale 1ns/1ps

module io_decode (
	input  logic [io_pkg::PORT_W-1:0] io_addr,
	input  logic [7:0]                sd_rdata,
	input  logic                      dsp_status_ok,
	output logic                      sel_lpt,
	output logic                      sel_dsp_cmd,
	output logic                      sel_sd,
	output logic [io_pkg::DATA_W-1:0] io_rdata
);

	logic                      sel_dsp_status;
	logic                      sel_dsp_ff;
	logic [7:0]                status_byte;
	logic [io_pkg::DATA_W-1:0] rd_status;
	logic [io_pkg::DATA_W-1:0] rd_ff;
	logic [io_pkg::DATA_W-1:0] rd_sd;

	// one select per device port
	assign sel_lpt        = io_addr == io_pkg::PORT_LPT;
	assign sel_dsp_cmd    = io_addr == io_pkg::PORT_DSP_CMD;
	assign sel_dsp_status = io_addr == io_pkg::PORT_DSP_STATUS;
	assign sel_dsp_ff     = io_addr == io_pkg::PORT_DSP_FF;
	assign sel_sd         = io_addr == io_pkg::PORT_SD;

	assign status_byte = dsp_status_ok ? 8'h01 : 8'haa; // id answer vs ready

	assign rd_status = {8'h00, status_byte};
	assign rd_ff     = {8'h00, 8'hff};
	assign rd_sd     = {sd_rdata, 8'h00}; // low byte was video sync, now zero

	// and-or read mux, selects are one-hot
	assign io_rdata =
		({io_pkg::DATA_W{sel_dsp_status}} & rd_status) |
		({io_pkg::DATA_W{sel_dsp_ff}}     & rd_ff) |
		({io_pkg::DATA_W{sel_sd}}         & rd_sd);

endmodule

//--- design/reset_gen.sv
`timescale 1ns/1ps

module reset_gen #(
	parameter int RESET_BITS = 19
) (
	input  logic clk_cpu,
	input  logic arst_n,
	input  logic cpu_ce,
	input  logic btn_reset,
	output logic sys_rst_n
);

	logic [RESET_BITS-1:0] rst_cnt;

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			rst_cnt <= '0;
		end else if (btn_reset) begin
			rst_cnt <= '0; // restart the stretch
		end else if (cpu_ce && !rst_cnt[RESET_BITS-1]) begin
			rst_cnt <= rst_cnt + 1'b1; // stops once top bit sets
		end
	end

	assign sys_rst_n = rst_cnt[RESET_BITS-1];

endmodule

//--- audio/dsp_port.sv
`timescale 1ns/1ps

module dsp_port (
	input  logic                        clk_cpu,
	input  logic                        arst_n,
	input  logic                        sys_rst_n,
	input  logic                        wr_strobe,
	input  logic                        sel_lpt,
	input  logic                        sel_dsp_cmd,
	input  logic [7:0]                  wdata,
	output logic [io_pkg::SAMPLE_W-1:0] sample,
	output logic                        dsp_status_ok
);

	logic [7:0]                  dsp_state;
	logic [io_pkg::SAMPLE_W-1:0] byte_sample;
	logic                        wr_lpt;
	logic                        wr_cmd;

	// 8-bit unsigned byte placed in bits 14..7
	assign byte_sample = {1'b0, wdata, 7'b0000000};

	assign wr_lpt = wr_strobe & sel_lpt;
	assign wr_cmd = wr_strobe & sel_dsp_cmd;

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			dsp_state <= 8'h00;
			sample    <= '0;
		end else begin
			if (wr_lpt)
				sample <= byte_sample;
			if (!sys_rst_n) begin
				dsp_state <= 8'h00;
			end else if (wr_cmd) begin
				case (dsp_state)
					8'h00: dsp_state <= wdata; // new command
					io_pkg::DSP_CMD_DIRECT: begin
						sample    <= byte_sample; // direct dac byte
						dsp_state <= 8'h00;
					end
					default: dsp_state <= 8'h00;
				endcase
			end
		end
	end

	assign dsp_status_ok = dsp_state == io_pkg::DSP_CMD_ID;

endmodule

//--- audio/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int SAMPLE_DIV_BITS = 8
) (
	input  logic                        clk_cpu,
	input  logic                        arst_n,
	input  logic [io_pkg::SAMPLE_W-1:0] sample,
	output logic                        aud
);

	localparam int HALF = io_pkg::ACC_W / 2;

	logic [SAMPLE_DIV_BITS:0]      clk_div;
	logic                          sample_stb;
	logic [io_pkg::SAMPLE_W-1:0]   sample_q;
	logic [io_pkg::SAMPLE_W-1:0]   target;
	logic [io_pkg::ACC_W-1:0]      acc;
	logic [io_pkg::ACC_W-1:0]      step;
	logic                          aud_next;

	// top bit is a one-cycle carry out of the low bits
	assign sample_stb = clk_div[SAMPLE_DIV_BITS];

	// offset binary to signed
	assign target = {~sample_q[io_pkg::SAMPLE_W-1], sample_q[io_pkg::SAMPLE_W-2:0]};

	assign aud_next = acc[io_pkg::ACC_W-1:HALF] < target;

	assign step = aud_next ?
		({{(io_pkg::ACC_W-1){1'b0}}, 1'b1} << io_pkg::STEP_BIT) : '0;

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			clk_div  <= '0;
			sample_q <= '0;
		end else begin
			clk_div <= {1'b0, clk_div[SAMPLE_DIV_BITS-1:0]} + 1'b1;
			if (sample_stb)
				sample_q <= sample;
		end
	end

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
			aud <= 1'b0;
		end else begin
			acc <= acc - (acc >> io_pkg::LEAK_SHIFT) + step; // leaky integrator
			aud <= aud_next;
		end
	end

endmodule

//--- sdcard/sd_spi_port.sv
`timescale 1ns/1ps

module sd_spi_port (
	input  logic                      clk_cpu,
	input  logic                      arst_n,
	input  logic                      cpu_ce,
	input  logic                      wr_strobe,
	input  logic                      word,
	input  logic                      sel_sd,
	input  logic                      sd_do,
	input  logic [io_pkg::DATA_W-1:0] wdata,
	output logic                      sd_ck,
	output logic                      sd_n_cs,
	output logic                      sd_di,
	output logic [7:0]                sd_rdata
);

	logic wr_sd;

	assign wr_sd = wr_strobe & sel_sd;

	// data out bit goes straight from the bus
	assign sd_di = wdata[7];

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			sd_ck    <= 1'b0;
			sd_n_cs  <= 1'b1; // card deselected
			sd_rdata <= 8'h00;
		end else if (cpu_ce) begin
			sd_ck <= wr_sd & ~word; // one pulse per byte write
			if (wr_sd) begin
				if (word)
					sd_n_cs <= ~wdata[8];
				else
					sd_rdata <= {sd_rdata[6:0], sd_do}; // msb first
			end
		end
	end

endmodule

//--- design/io_system.sv
`timescale 1ns/1ps

module io_system #(
	parameter int RESET_BITS      = 19,
	parameter int SAMPLE_DIV_BITS = 8
) (
	input  logic                      clk_cpu,
	input  logic                      arst_n,
	input  logic [io_pkg::PORT_W-1:0] io_addr,
	input  logic [io_pkg::DATA_W-1:0] io_wdata,
	input  logic                      iorq,
	input  logic                      wr,
	input  logic                      word,
	input  logic                      cpu_ce,
	input  logic                      btn_reset,
	input  logic                      sd_do,
	output logic [io_pkg::DATA_W-1:0] io_rdata,
	output logic                      sd_ck,
	output logic                      sd_n_cs,
	output logic                      sd_di,
	output logic                      aud,
	output logic                      sys_rst_n
);

	logic                        wr_strobe;
	logic                        sel_lpt;
	logic                        sel_dsp_cmd;
	logic                        sel_sd;
	logic                        dsp_status_ok;
	logic [7:0]                  sd_rdata;
	logic [io_pkg::SAMPLE_W-1:0] sample;

	assign wr_strobe = iorq & wr & cpu_ce; // single qualified write

	io_decode u_decode (
		.io_addr       (io_addr),
		.sd_rdata      (sd_rdata),
		.dsp_status_ok (dsp_status_ok),
		.sel_lpt       (sel_lpt),
		.sel_dsp_cmd   (sel_dsp_cmd),
		.sel_sd        (sel_sd),
		.io_rdata      (io_rdata)
	);

	reset_gen #(
		.RESET_BITS (RESET_BITS)
	) u_reset (
		.clk_cpu   (clk_cpu),
		.arst_n    (arst_n),
		.cpu_ce    (cpu_ce),
		.btn_reset (btn_reset),
		.sys_rst_n (sys_rst_n)
	);

	dsp_port u_dsp (
		.clk_cpu       (clk_cpu),
		.arst_n        (arst_n),
		.sys_rst_n     (sys_rst_n),
		.wr_strobe     (wr_strobe),
		.sel_lpt       (sel_lpt),
		.sel_dsp_cmd   (sel_dsp_cmd),
		.wdata         (io_wdata[7:0]),
		.sample        (sample),
		.dsp_status_ok (dsp_status_ok)
	);

	sigma_delta_dac #(
		.SAMPLE_DIV_BITS (SAMPLE_DIV_BITS)
	) u_dac (
		.clk_cpu (clk_cpu),
		.arst_n  (arst_n),
		.sample  (sample),
		.aud     (aud)
	);

	sd_spi_port u_sd (
		.clk_cpu   (clk_cpu),
		.arst_n    (arst_n),
		.cpu_ce    (cpu_ce),
		.wr_strobe (wr_strobe),
		.word      (word),
		.sel_sd    (sel_sd),
		.sd_do     (sd_do),
		.wdata     (io_wdata),
		.sd_ck     (sd_ck),
		.sd_n_cs   (sd_n_cs),
		.sd_di     (sd_di),
		.sd_rdata  (sd_rdata)
	);

endmodule

//--- tests/tb_io_checks.svh
`ifndef TB_IO_CHECKS_SVH
`define TB_IO_CHECKS_SVH

int    check_count;
int    error_count;
int    tests_run;
int    tests_failed;
int    errors_at_start;
string cur_test = "init";

task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	check_count++;
	if (expected !== actual) begin
		error_count++;
		$display("Error %s expected %h actual %h", name, expected, actual);
	end
endtask

task automatic begin_test(input string name);
	cur_test        = name;
	errors_at_start = error_count;
endtask

task automatic end_test();
	tests_run++;
	if (error_count != errors_at_start) begin
		tests_failed++;
		$display("test %s: %0d errors", cur_test, error_count - errors_at_start);
	end else begin
		$display("test %s: ok", cur_test);
	end
endtask

function automatic logic [15:0] dsp_status_ref(input logic [7:0] state);
	return (state == io_pkg::DSP_CMD_ID) ? 16'h0001 : 16'h00aa;
endfunction

function automatic logic [7:0] sd_shift_ref(input logic [7:0] sr, input logic din);
	return {sr[6:0], din}; // new bit enters at the low end
endfunction

function automatic logic [15:0] byte_to_sample(input logic [7:0] b);
	return {1'b0, b, 7'd0};
endfunction

// output bit of the modulator for the current accumulator and latched sample
function automatic logic sdm_bit_ref(input logic [31:0] acc, input logic [15:0] smp);
	logic [15:0] target;
	target = smp ^ 16'h8000; // offset to signed
	return acc[31:16] < target;
endfunction

function automatic logic [31:0] sdm_acc_ref(input logic [31:0] acc, input logic aud_bit);
	logic [31:0] step;
	step = aud_bit ? (32'd1 << io_pkg::STEP_BIT) : 32'd0;
	return acc - (acc >> io_pkg::LEAK_SHIFT) + step;
endfunction

`endif

//--- tests/tb_io_system.sv
`timescale 1ns/1ps

module tb_io_system;

	localparam int          CLK_PERIOD  = 100;
	localparam int          DRIVE_DELAY = 5;
	localparam int          TEST_CYCLES = 1000; // all tests together, rounded up
	localparam int          RESET_BITS  = 4;
	localparam int          DIV_BITS    = 3;
	localparam logic [31:0] SEED        = 32'h3e45_3cee;

	logic        clk_cpu;
	logic        arst_n;
	logic [15:0] io_addr;
	logic [15:0] io_wdata;
	logic        iorq;
	logic        wr;
	logic        word;
	logic        cpu_ce;
	logic        btn_reset;
	logic        sd_do;
	logic [15:0] io_rdata;
	logic        sd_ck;
	logic        sd_n_cs;
	logic        sd_di;
	logic        aud;
	logic        sys_rst_n;

	// reference model state
	logic [7:0]  m_state = 8'h00;
	logic [15:0] m_sample = '0;
	logic [15:0] m_sample_q = '0;
	logic [31:0] m_acc = '0;
	logic [7:0]  m_sd = 8'h00;
	int          m_edges;
	int          aud_high_dut;
	int          aud_high_model;

	`include "tb_io_checks.svh"

	io_system #(
		.RESET_BITS      (RESET_BITS),
		.SAMPLE_DIV_BITS (DIV_BITS)
	) uut (
		.clk_cpu (clk_cpu), .arst_n (arst_n), .io_addr (io_addr), .io_wdata (io_wdata),
		.iorq (iorq), .wr (wr), .word (word), .cpu_ce (cpu_ce), .btn_reset (btn_reset),
		.sd_do (sd_do), .io_rdata (io_rdata), .sd_ck (sd_ck), .sd_n_cs (sd_n_cs),
		.sd_di (sd_di), .aud (aud), .sys_rst_n (sys_rst_n)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
	end

	task automatic cycle();
		@(posedge clk_cpu);
		#DRIVE_DELAY;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [15:0] data,
			input logic is_word);
		io_addr  = addr;
		io_wdata = data;
		word     = is_word;
		iorq     = 1'b1;
		wr       = 1'b1;
		cycle();
		iorq = 1'b0;
		wr   = 1'b0;
		word = 1'b0;
	endtask

	task automatic io_read_check(input logic [15:0] addr, input logic [15:0] expected);
		io_addr = addr;
		iorq    = 1'b1;
		wr      = 1'b0;
		@(negedge clk_cpu); // read path is combinational
		check(cur_test, expected, io_rdata);
		cycle();
		iorq = 1'b0;
	endtask

	task automatic count_to_release(output int n);
		n = 0;
		while (sys_rst_n !== 1'b1 && n < 32) begin
			cycle();
			n++;
		end
	endtask

	// per-edge model of the dsp writes and the modulator
	initial begin : compare
		logic stb;
		logic exp_aud;
		wait (arst_n === 1'b1);
		forever begin
			@(posedge clk_cpu);
			#1;
			stb     = (m_edges != 0) && (m_edges % (1 << DIV_BITS) == 0);
			exp_aud = sdm_bit_ref(m_acc, m_sample_q);
			m_acc   = sdm_acc_ref(m_acc, exp_aud);
			if (stb)
				m_sample_q = m_sample; // old sample, before this edge's write
			if (iorq && wr && cpu_ce && io_addr == io_pkg::PORT_LPT) begin
				m_sample = byte_to_sample(io_wdata[7:0]);
			end else if (iorq && wr && cpu_ce && io_addr == io_pkg::PORT_DSP_CMD) begin
				if (m_state == 8'h00) begin
					m_state = io_wdata[7:0];
				end else begin
					if (m_state == io_pkg::DSP_CMD_DIRECT)
						m_sample = byte_to_sample(io_wdata[7:0]);
					m_state = 8'h00;
				end
			end
			m_edges++;
			check({cur_test, " aud"}, exp_aud, aud);
			aud_high_dut   += aud;
			aud_high_model += exp_aud;
		end
	end

	initial begin : stimulus
		int          n;
		logic [7:0]  rnd_byte;
		logic        rnd_bit;
		logic [15:0] rnd_word;
		void'($urandom(SEED));
		arst_n = 1'b0;
		io_addr = '0;
		io_wdata = '0;
		iorq = 1'b0;
		wr = 1'b0;
		word = 1'b0;
		cpu_ce = 1'b1;
		btn_reset = 1'b0;
		sd_do = 1'b0;

		begin_test("reset");
		repeat (2) cycle();
		arst_n = 1'b1;
		check(cur_test, 1, sd_n_cs);
		check(cur_test, 0, sd_ck);
		check(cur_test, 0, sys_rst_n);
		count_to_release(n);
		check(cur_test, 1 << (RESET_BITS - 1), n);
		btn_reset = 1'b1;
		cycle();
		btn_reset = 1'b0;
		check(cur_test, 0, sys_rst_n);
		count_to_release(n);
		check(cur_test, 1 << (RESET_BITS - 1), n);
		end_test();

		begin_test("dsp");
		io_read_check(io_pkg::PORT_DSP_STATUS, dsp_status_ref(m_state));
		io_write(io_pkg::PORT_DSP_CMD, 16'h00e1, 1'b0);
		io_read_check(io_pkg::PORT_DSP_STATUS, dsp_status_ref(m_state));
		io_write(io_pkg::PORT_DSP_CMD, 16'h0042, 1'b0);
		io_read_check(io_pkg::PORT_DSP_STATUS, dsp_status_ref(m_state));
		io_read_check(io_pkg::PORT_DSP_FF, 16'h00ff);
		io_read_check(16'h0300, 16'h0000);
		end_test();

		begin_test("audio");
		rnd_byte = 8'($urandom);
		io_write(io_pkg::PORT_DSP_CMD, {8'h00, io_pkg::DSP_CMD_DIRECT}, 1'b0);
		io_write(io_pkg::PORT_DSP_CMD, {8'h00, rnd_byte}, 1'b0);
		repeat (64) cycle();
		rnd_byte = 8'($urandom);
		io_write(io_pkg::PORT_LPT, {8'h00, rnd_byte}, 1'b0);
		aud_high_dut   = 0;
		aud_high_model = 0;
		repeat (256) cycle();
		check(cur_test, aud_high_model, aud_high_dut);
		end_test();

		begin_test("sd_shift");
		for (int i = 0; i < 8; i++) begin
			rnd_bit = 1'($urandom);
			sd_do   = rnd_bit;
			io_write(io_pkg::PORT_SD, 16'h0000, 1'b0);
			m_sd = sd_shift_ref(m_sd, rnd_bit);
			check(cur_test, 1, sd_ck);
			cycle();
			check(cur_test, 0, sd_ck); // single pulse
		end
		io_read_check(io_pkg::PORT_SD, {m_sd, 8'h00});
		cpu_ce = 1'b0;
		sd_do  = ~sd_do;
		io_write(io_pkg::PORT_SD, 16'h0000, 1'b0);
		check(cur_test, 0, sd_ck);
		io_write(io_pkg::PORT_SD, 16'h0100, 1'b1);
		check(cur_test, 1, sd_n_cs);
		cpu_ce = 1'b1;
		io_read_check(io_pkg::PORT_SD, {m_sd, 8'h00});
		end_test();

		begin_test("sd_cs");
		io_write(io_pkg::PORT_SD, 16'h0100, 1'b1);
		check(cur_test, 0, sd_n_cs);
		check(cur_test, 0, sd_ck);
		io_write(io_pkg::PORT_SD, 16'h0000, 1'b1);
		check(cur_test, 1, sd_n_cs);
		repeat (4) begin
			rnd_word = 16'($urandom);
			io_wdata = rnd_word;
			@(negedge clk_cpu);
			check(cur_test, rnd_word[7], sd_di);
			cycle();
		end
		end_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin : watchdog
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", 2 * TEST_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+tests
common/io_pkg.sv
design/io_decode.sv
design/reset_gen.sv
audio/dsp_port.sv
audio/sigma_delta_dac.sv
sdcard/sd_spi_port.sv
design/io_system.sv
tests/tb_io_system.sv
